// File: dv/etx_tb.sv
// Link transmitter testbench
// Clock, reset, packet stimulus, reference byte queue, checking assertions, watchdog

`timescale 1ns/1ps
`include "etx_params.svh"

module etx_tb import etx_pkg::*; ();

   localparam int PKT_BYTES      = 2 * `ETX_BYTES;  // Header beat plus tail beat
   localparam int N_PKT          = 14;              // Packets sent over all tests
   localparam int N_TEST         = 6;
   localparam int WATCHDOG_CYC   = 40 * N_PKT + 200 * N_TEST;
   localparam int ACCEPT_TIMEOUT = 100;
   localparam int DRAIN_TIMEOUT  = 100;
   localparam int SETTLE         = 12;              // Sync depth plus one full word

   logic        txlclk_out = 1'b0;
   logic        arst_n;
   etx_packet_t pkt;
   logic        pkt_valid;
   etx_cfg_t    cfg;
   logic        tx_wr_wait;
   logic        tx_rd_wait;
   logic        pkt_ready;
   logic [7:0]  tx_data;
   logic        tx_frame;
   logic        rd_wait;

   int          seed;
   logic [31:0] rnd;
   int          err_cnt   = 0;
   int          err_mark  = 0;
   int          n_tests   = 0;
   int          pkts_seen = 0;

   etx_packet_t exp_q[$];               // Accepted packets not yet seen on the link
   etx_packet_t cur_pkt;                // Packet the monitor is walking through
   int          mon_idx;                // Byte slot within cur_pkt
   logic        mon_en;                 // Off while the pins carry GPIO levels
   logic        chk_on;
   logic        extra_pkt;
   logic        prev_frame;
   logic [7:0]  exp_data;
   logic        exp_frame;

   int          post_rst_cnt;           // Cycles since reset release
   int          wr_wait_cnt;            // Cycles the write wait has been high
   int          gpio_cnt;
   int          dis_cnt;
   int          rd_cnt;                 // Cycles the read wait input held its level
   logic        rd_prev;

   always #5 txlclk_out = ~txlclk_out;  // 100 MHz link clock

   etx_top u_etx_top (
      .txlclk_out (txlclk_out),
      .arst_n     (arst_n),
      .pkt        (pkt),
      .pkt_valid  (pkt_valid),
      .cfg        (cfg),
      .tx_wr_wait (tx_wr_wait),
      .tx_rd_wait (tx_rd_wait),
      .pkt_ready  (pkt_ready),
      .tx_data    (tx_data),
      .tx_frame   (tx_frame),
      .rd_wait    (rd_wait)
   );

   //########################################
   // Reference model
   //########################################
   function automatic logic [7:0] layout_byte(input etx_packet_t p, input int idx);
      logic [7:0] b;
      case (idx)
         0:       b = {p.opcode, 2'b00, p.ctrlmode};  // Header byte
         1:       b = p.dstaddr[31:24];
         2:       b = p.dstaddr[23:16];
         3:       b = p.dstaddr[15:8];
         4:       b = p.dstaddr[7:0];
         5:       b = p.data[31:24];
         6:       b = p.data[23:16];
         7:       b = p.data[15:8];
         8:       b = p.data[7:0];                    // First byte of the tail beat
         default: b = 8'h00;                          // Tail padding
      endcase
      return b;
   endfunction

   function automatic logic layout_frame(input int idx);
      return (idx <= 8);                // Full header beat plus first tail byte
   endfunction

   function automatic etx_packet_t make_pkt(input etx_opcode_e op);
      etx_packet_t p;
      logic [31:0] r;
      r          = $random(seed);
      p.opcode   = op;
      p.ctrlmode = r[3:0];
      p.dstaddr  = $random(seed);
      p.data     = $random(seed);
      return p;
   endfunction

   // Walks the expected bytes from each frame rising edge at mid-cycle
   always @(negedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         mon_idx    = PKT_BYTES;
         chk_on     = 1'b0;
         extra_pkt  = 1'b0;
         prev_frame = 1'b0;
         exp_data   = 8'h00;
         exp_frame  = 1'b0;
      end else begin
         extra_pkt = 1'b0;
         if (mon_en && tx_frame && !prev_frame && mon_idx >= PKT_BYTES) begin
            if (exp_q.size() == 0) begin
               extra_pkt = 1'b1;        // Frame with nothing accepted
            end else begin
               cur_pkt = exp_q.pop_front();
               mon_idx = 0;
               pkts_seen++;
            end
         end
         if (mon_en && mon_idx < PKT_BYTES) begin
            exp_data  = layout_byte(cur_pkt, mon_idx);
            exp_frame = layout_frame(mon_idx);
            chk_on    = 1'b1;
            mon_idx++;
         end else begin
            chk_on = 1'b0;
         end
         prev_frame = tx_frame;
      end
   end

   // Level-duration counters for the config checks
   always @(posedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         post_rst_cnt <= 0;
         wr_wait_cnt  <= 0;
         gpio_cnt     <= 0;
         dis_cnt      <= 0;
         rd_cnt       <= 0;
         rd_prev      <= 1'b0;
      end else begin
         post_rst_cnt <= post_rst_cnt + 1;
         wr_wait_cnt  <= tx_wr_wait ? wr_wait_cnt + 1 : 0;
         gpio_cnt     <= cfg.gpio_mode ? gpio_cnt + 1 : 0;
         dis_cnt      <= cfg.enable ? 0 : dis_cnt + 1;
         rd_cnt       <= (tx_rd_wait == rd_prev) ? rd_cnt + 1 : 0;
         rd_prev      <= tx_rd_wait;
      end
   end

   //########################################
   // Checks
   //########################################
   reset_quiet: assert property (@(posedge txlclk_out)
      post_rst_cnt < 2 |-> !pkt_ready && !tx_frame && tx_data == 8'h00)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t pkt_ready/tx_frame/tx_data expected 0/0/00 actual %b/%b/%02h",
                  $time, $sampled(pkt_ready), $sampled(tx_frame), $sampled(tx_data));
      end

   byte_matches: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      chk_on |-> tx_data == exp_data)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t tx_data expected %02h actual %02h",
                  $time, $sampled(exp_data), $sampled(tx_data));
      end

   frame_matches: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      chk_on |-> tx_frame == exp_frame)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t tx_frame expected %b actual %b",
                  $time, $sampled(exp_frame), $sampled(tx_frame));
      end

   no_extra_packet: assert property (@(posedge txlclk_out) disable iff (!arst_n) !extra_pkt)
      else begin
         err_cnt++;
         $display("frame started at t=%0t with no accepted packet left", $time);
      end

   wait_blocks_ready: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      wr_wait_cnt >= 3 |-> !pkt_ready)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t pkt_ready expected 0 actual %b", $time, $sampled(pkt_ready));
      end

   gpio_data_pins: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      gpio_cnt >= SETTLE |-> tx_data == cfg.dataout[7:0])
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t tx_data expected %02h actual %02h",
                  $time, $sampled(cfg.dataout[7:0]), $sampled(tx_data));
      end

   gpio_frame_ready: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      gpio_cnt >= SETTLE |-> tx_frame == cfg.dataout[`ETX_GPIO_W-1] && !pkt_ready)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t tx_frame/pkt_ready expected %b/0 actual %b/%b", $time,
                  $sampled(cfg.dataout[`ETX_GPIO_W-1]), $sampled(tx_frame), $sampled(pkt_ready));
      end

   disable_quiets_pins: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      dis_cnt >= SETTLE |-> tx_data == 8'h00 && !tx_frame && !pkt_ready)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t tx_data/tx_frame/pkt_ready expected 00/0/0 actual %02h/%b/%b",
                  $time, $sampled(tx_data), $sampled(tx_frame), $sampled(pkt_ready));
      end

   rd_wait_follows: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      rd_cnt >= 2 |-> rd_wait == rd_prev)
      else begin
         err_cnt++;
         $display("[FAIL] t=%0t rd_wait expected %b actual %b",
                  $time, $sampled(rd_prev), $sampled(rd_wait));
      end

   //########################################
   // Stimulus
   //########################################
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge txlclk_out);
      #1;                               // Drive point after the edge
   endtask

   task automatic send_pkt(input etx_packet_t p, input logic keep_valid);
      int   waited;
      logic taken;
      waited    = 0;
      taken     = 1'b0;
      pkt       = p;
      pkt_valid = 1'b1;
      while (!taken && waited < ACCEPT_TIMEOUT) begin
         @(negedge txlclk_out);         // Ready is settled mid-cycle
         if (pkt_ready) begin
            @(posedge txlclk_out);      // Transfer edge
            exp_q.push_back(p);
            taken = 1'b1;
         end else begin
            waited++;
         end
      end
      if (!taken) begin
         err_cnt++;
         $display("packet was not accepted within %0d cycles", ACCEPT_TIMEOUT);
         @(posedge txlclk_out);
      end
      #1;
      if (!keep_valid) begin
         pkt_valid = 1'b0;
      end
   endtask

   task automatic drain_stream();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0 || mon_idx < PKT_BYTES) && waited < DRAIN_TIMEOUT) begin
         @(posedge txlclk_out);
         waited++;
      end
      wait_cycles(1);
      assert (exp_q.size() == 0 && mon_idx >= PKT_BYTES) else begin
         err_cnt++;
         $display("link stream did not finish, %0d accepted packets still unseen",
                  exp_q.size());
      end
      exp_q.delete();
   endtask

   task automatic finish_test(input string name);
      int n;
      n = err_cnt - err_mark;
      n_tests++;
      if (n == 0) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         $display("test %0d %s: %0d errors", n_tests, name, n);
      end
      err_mark = err_cnt;
   endtask

   initial begin
      seed          = 32'h2f09b2d3;
      arst_n        = 1'b1;
      pkt           = '0;
      pkt_valid     = 1'b0;
      cfg.enable    = 1'b1;
      cfg.gpio_mode = 1'b0;
      cfg.dataout   = '0;
      tx_wr_wait    = 1'b0;
      tx_rd_wait    = 1'b0;
      mon_en        = 1'b1;
      #1 arst_n = 1'b0;
      repeat (16) @(posedge txlclk_out);
      #1 arst_n = 1'b1;
      wait_cycles(8);
      finish_test("reset");

      send_pkt(make_pkt(OP_WRITE), 1'b0);
      drain_stream();
      send_pkt(make_pkt(OP_READ), 1'b0);
      drain_stream();
      finish_test("single packets");

      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         send_pkt(make_pkt(rnd[0] ? OP_READ : OP_WRITE), i < 7);  // Valid stays high
      end
      drain_stream();
      finish_test("back-to-back");

      send_pkt(make_pkt(OP_WRITE), 1'b0);
      tx_wr_wait = 1'b1;                // Raised while the packet is in flight
      pkt        = make_pkt(OP_READ);
      pkt_valid  = 1'b1;                // Offered but held off by the wait
      wait_cycles(30);
      tx_wr_wait = 1'b0;
      send_pkt(pkt, 1'b0);
      drain_stream();
      finish_test("write wait");

      mon_en        = 1'b0;             // Pins carry a constant pattern
      rnd           = $random(seed);
      cfg.dataout   = {1'b1, rnd[7:0]};
      cfg.gpio_mode = 1'b1;
      wait_cycles(40);
      cfg.gpio_mode = 1'b0;
      wait_cycles(SETTLE);
      mon_en = 1'b1;
      send_pkt(make_pkt(OP_WRITE), 1'b0);
      drain_stream();
      finish_test("gpio mode");

      cfg.enable = 1'b0;
      tx_rd_wait = 1'b1;
      wait_cycles(20);
      tx_rd_wait = 1'b0;
      wait_cycles(20);
      cfg.enable = 1'b1;
      tx_rd_wait = 1'b1;
      wait_cycles(10);
      tx_rd_wait = 1'b0;
      wait_cycles(SETTLE);
      send_pkt(make_pkt(OP_READ), 1'b0);
      drain_stream();
      finish_test("disable and read wait");

      $display("summary: %0d tests, %0d packets checked, %0d errors",
               n_tests, pkts_seen, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Run length bound from packet count and test count
   initial begin
      repeat (WATCHDOG_CYC) @(posedge txlclk_out);
      $display("watchdog expired after %0d cycles, test sequence did not finish", WATCHDOG_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: flist.f
+incdir+source
source/etx_pkg.sv
source/etx_cfg_sync.sv
source/etx_framer.sv
source/etx_serializer.sv
source/etx_top.sv
dv/etx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the link transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module etx_tb -o etx_sim

# Pipe status is the status of tee, the log decides pass or fail
./obj_dir/etx_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: source/etx_cfg_sync.sv
// Control synchronizers into the link clock
// Enable, GPIO mode, write wait and read wait

`timescale 1ns/1ps
`include "etx_params.svh"

module etx_cfg_sync import etx_pkg::*; #(
   parameter int STAGES = `ETX_SYNC_STAGES
) (
   input  logic     txlclk_out,
   input  logic     arst_n,
   input  etx_cfg_t cfg,                // Raw configuration, async
   input  logic     wr_wait_in,         // Far-end write wait, async
   input  logic     rd_wait_in,         // Far-end read wait, async
   output logic     enable_s,
   output logic     gpio_s,
   output logic     wr_wait_s,
   output logic     rd_wait_s
);

   logic [3:0]             raw;         // Bits gathered for one chain per bit
   logic [STAGES-1:0][3:0] sync_q;      // Stage 0 samples, last stage is output

   assign raw = {cfg.enable, cfg.gpio_mode, wr_wait_in, rd_wait_in};

   // Plain shift chain, all stages cleared in reset
   always_ff @(posedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= raw;              // First capture, may go metastable
         for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign enable_s  = sync_q[STAGES-1][3];
   assign gpio_s    = sync_q[STAGES-1][2];
   assign wr_wait_s = sync_q[STAGES-1][1];
   assign rd_wait_s = sync_q[STAGES-1][0];

endmodule

// File: source/etx_framer.sv
// Packet framer
// Host packet in, header beat then tail beat out under valid/ready

`timescale 1ns/1ps
`include "etx_params.svh"

module etx_framer import etx_pkg::*; (
   input  logic        txlclk_out,
   input  logic        arst_n,
   input  etx_packet_t pkt,             // Host transaction
   input  logic        pkt_valid,
   input  logic        enable_s,        // Synchronized link enable
   input  logic        gpio_s,          // Synchronized GPIO mode
   input  logic        wr_wait_s,       // Synchronized far-end wait
   input  logic        beat_ready,      // Serializer takes a beat
   output logic        pkt_ready,
   output etx_beat_t   beat,
   output logic        beat_valid
);

   etx_frm_state_e state;
   etx_frm_state_e state_nxt;
   etx_packet_t    pkt_q;               // Packet held for both beats
   logic           pkt_fire;
   logic           beat_fire;
   logic [7:0]     hdr_byte;            // Opcode and ctrlmode byte

   //########################################
   // Handshakes
   //########################################
   // New packets only start from idle with a clean link
   assign pkt_ready  = (state == FRM_IDLE) && enable_s && !gpio_s && !wr_wait_s;
   assign pkt_fire   = pkt_valid && pkt_ready;
   assign beat_valid = (state != FRM_IDLE);
   assign beat_fire  = beat_valid && beat_ready;

   //########################################
   // State machine
   //########################################
   always_comb begin
      state_nxt = state;
      case (state)
         FRM_IDLE: if (pkt_fire)  state_nxt = FRM_HEAD;
         FRM_HEAD: if (beat_fire) state_nxt = FRM_TAIL;  // Wait is ignored mid-packet
         FRM_TAIL: if (beat_fire) state_nxt = FRM_IDLE;
         default:  state_nxt = FRM_IDLE;
      endcase
   end

   always_ff @(posedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         state <= FRM_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge txlclk_out) begin
      if (pkt_fire) begin
         pkt_q <= pkt;                  // Capture on acceptance only
      end
   end

   //########################################
   // Beat build
   //########################################
   assign hdr_byte = {pkt_q.opcode, 2'b00, pkt_q.ctrlmode};

   always_comb begin
      beat = '0;                        // Idle shows an empty beat
      case (state)
         FRM_HEAD: begin
            beat.frame = '1;                                    // Every byte framed
            beat.data  = {hdr_byte, pkt_q.dstaddr, pkt_q.data[31:8]};
         end
         FRM_TAIL: begin
            beat.frame = {1'b1, {(`ETX_BYTES-1){1'b0}}};        // Last data byte only
            beat.data  = {pkt_q.data[7:0], {(`ETX_BYTES*8-8){1'b0}}};
         end
         default: ;
      endcase
   end

   // Offered beat holds still until taken
   a_beat_hold: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      beat_valid && !beat_ready |=> beat_valid && $stable(beat));

endmodule

// File: source/etx_params.svh
// Link transmitter parameters
// Beat size, synchronizer depth and GPIO drive width

`ifndef ETX_PARAMS_SVH
`define ETX_PARAMS_SVH

//########################################
// Beat geometry
//########################################
`define ETX_BYTES 8                     // Bytes per beat, one per link clock

//########################################
// Clock domain crossing
//########################################
`define ETX_SYNC_STAGES 2               // Flops per synchronized control bit

//########################################
// GPIO drive word
//########################################
`define ETX_GPIO_W 9                    // Bits 7..0 byte, bit 8 frame level

`endif

// File: source/etx_pkg.sv
// Link transmitter types
// Opcode and framer state enums, packet, beat and configuration structs

`include "etx_params.svh"

package etx_pkg;

   //########################################
   // Enums
   //########################################
   typedef enum logic [1:0] {
      OP_WRITE = 2'b00,                 // Posted write
      OP_READ  = 2'b01                  // Read, data field holds return address
   } etx_opcode_e;

   typedef enum logic [1:0] {
      FRM_IDLE = 2'b00,                 // Waiting for a host packet
      FRM_HEAD = 2'b01,                 // Header beat on offer
      FRM_TAIL = 2'b10                  // Tail beat on offer
   } etx_frm_state_e;

   //########################################
   // Structs
   //########################################
   typedef struct packed {
      etx_opcode_e opcode;              // Transaction type
      logic [3:0]  ctrlmode;            // Passed through in header byte
      logic [31:0] dstaddr;             // Target address
      logic [31:0] data;                // Write data or read return address
   } etx_packet_t;

   typedef struct packed {
      logic [`ETX_BYTES-1:0]   frame;   // One bit per byte, MSB first
      logic [`ETX_BYTES*8-1:0] data;    // Top byte goes out first
   } etx_beat_t;

   typedef struct packed {
      logic                   enable;    // Link enable, async
      logic                   gpio_mode; // Force constant pattern on pins
      logic [`ETX_GPIO_W-1:0] dataout;   // GPIO byte and frame level
   } etx_cfg_t;

endpackage

// File: source/etx_serializer.sv
// Beat serializer
// Parallel word register with GPIO/data/zero mux and byte-wide shifter

`timescale 1ns/1ps
`include "etx_params.svh"

module etx_serializer import etx_pkg::*; (
   input  logic                   txlclk_out,
   input  logic                   arst_n,
   input  etx_beat_t              beat,        // Beat from framer
   input  logic                   beat_valid,
   input  logic                   enable_s,    // Synchronized link enable
   input  logic                   gpio_s,      // Synchronized GPIO mode
   input  logic [`ETX_GPIO_W-1:0] gpio_data,   // Constant pin pattern
   output logic                   beat_ready,
   output logic [7:0]             tx_data,     // Link data pins
   output logic                   tx_frame     // Link frame pin
);

   localparam int               CNT_W = $clog2(`ETX_BYTES);
   localparam logic [CNT_W-1:0] LAST  = CNT_W'(`ETX_BYTES - 1);

   logic [`ETX_BYTES*8-1:0] pdata;      // Parallel data with top byte on pins
   logic [`ETX_BYTES-1:0]   pframe;     // Parallel frame with top bit on pin
   logic [CNT_W-1:0]        byte_cnt;   // Byte slot within the word
   logic                    load;       // Last byte showing so reload next edge

   assign load       = (byte_cnt == LAST);
   assign beat_ready = load && enable_s && !gpio_s;  // Take a beat only in data mode

   //########################################
   // Byte counter
   //########################################
   always_ff @(posedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         byte_cnt <= '0;
      end else if (load) begin
         byte_cnt <= '0;
      end else begin
         byte_cnt <= byte_cnt + 1'b1;
      end
   end

   //########################################
   // Parallel register and shifter
   //########################################
   // Word reloads on the last byte and shifts up one byte otherwise
   always_ff @(posedge txlclk_out or negedge arst_n) begin
      if (!arst_n) begin
         pdata  <= '0;
         pframe <= '0;
      end else if (load) begin
         if (gpio_s) begin
            pframe <= {`ETX_BYTES{gpio_data[`ETX_GPIO_W-1]}};  // GPIO wins
            pdata  <= {`ETX_BYTES{gpio_data[7:0]}};
         end else if (enable_s && beat_valid) begin
            pframe <= beat.frame;                             // Normal traffic
            pdata  <= beat.data;
         end else begin
            pframe <= '0;                                     // Disabled or no beat
            pdata  <= '0;
         end
      end else begin
         pdata  <= pdata << 8;          // Next byte to the top
         pframe <= pframe << 1;
      end
   end

   assign tx_data  = pdata[`ETX_BYTES*8-1 -: 8];
   assign tx_frame = pframe[`ETX_BYTES-1];

   //########################################
   // Checks
   //########################################
   a_no_ready_gpio: assert property (@(posedge txlclk_out) disable iff (!arst_n)
      gpio_s |-> !beat_ready);

endmodule

// File: source/etx_top.sv
// Link transmitter top level
// Synchronizers, framer and serializer wired to host ports and link pins

`timescale 1ns/1ps

module etx_top import etx_pkg::*; (
   input  logic        txlclk_out,
   input  logic        arst_n,
   input  etx_packet_t pkt,             // Host transaction
   input  logic        pkt_valid,
   input  etx_cfg_t    cfg,             // Raw configuration
   input  logic        tx_wr_wait,      // Far-end write wait pin
   input  logic        tx_rd_wait,      // Far-end read wait pin
   output logic        pkt_ready,
   output logic [7:0]  tx_data,         // Link data pins
   output logic        tx_frame,        // Link frame pin
   output logic        rd_wait          // Read wait back to host
);

   logic      enable_s;
   logic      gpio_s;
   logic      wr_wait_s;
   etx_beat_t beat;                     // Framer to serializer
   logic      beat_valid;
   logic      beat_ready;

   //########################################
   // Control sync
   //########################################
   etx_cfg_sync u_etx_cfg_sync (
      .txlclk_out (txlclk_out),
      .arst_n     (arst_n),
      .cfg        (cfg),
      .wr_wait_in (tx_wr_wait),
      .rd_wait_in (tx_rd_wait),
      .enable_s   (enable_s),
      .gpio_s     (gpio_s),
      .wr_wait_s  (wr_wait_s),
      .rd_wait_s  (rd_wait)             // Straight out to host
   );

   //########################################
   // Datapath
   //########################################
   etx_framer u_etx_framer (
      .txlclk_out (txlclk_out),
      .arst_n     (arst_n),
      .pkt        (pkt),
      .pkt_valid  (pkt_valid),
      .enable_s   (enable_s),
      .gpio_s     (gpio_s),
      .wr_wait_s  (wr_wait_s),
      .beat_ready (beat_ready),
      .pkt_ready  (pkt_ready),
      .beat       (beat),
      .beat_valid (beat_valid)
   );

   etx_serializer u_etx_serializer (
      .txlclk_out (txlclk_out),
      .arst_n     (arst_n),
      .beat       (beat),
      .beat_valid (beat_valid),
      .enable_s   (enable_s),
      .gpio_s     (gpio_s),
      .gpio_data  (cfg.dataout),        // Quasi-static, sampled directly
      .beat_ready (beat_ready),
      .tx_data    (tx_data),
      .tx_frame   (tx_frame)
   );

endmodule
